//--- Makefile
TOP = tb_wb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir -o sim_wb

run: build
	./obj_dir/sim_wb | tee sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- compile.f
la_exc_pkg.sv
la_csr_pkg.sv
writeback.sv
regfile.sv
csr_file.sv
wb_top.sv
tb_clkgen.sv
tb_wb_top.sv

//--- csr_file.sv
`timescale 1ns/1ps

module csr_file
    import la_csr_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  exc_upd_t    exc_upd,
    input  csr_wr_t     csr_wr,
    input  csr_addr_t   raddr,
    output logic [31:0] rdata,
    output logic [31:0] eentry,
    output logic [31:0] tlbrentry
);

    crmd_t                 crmd;
    prmd_t                 prmd;
    crmd_t                 sw_crmd;
    prmd_t                 sw_prmd;
    logic [ECODE_W-1:0]    estat_ecode;
    logic [31:0]           era;
    logic [31:0]           badv;
    logic [VPPN_W-1:0]     tlbehi_vppn;
    logic [PGD_BASE_W-1:0] pgdl_base;
    logic [PGD_BASE_W-1:0] pgdh_base;
    logic [PGD_BASE_W-1:0] pgd_base;

    function automatic logic sw_hit(input csr_addr_t a);
        return csr_wr.en && (csr_wr.addr == a);
    endfunction

    assign sw_crmd = crmd_t'(csr_wr.data);
    assign sw_prmd = prmd_t'(csr_wr.data);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // An exception beats software on each CSR it touches
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd        <= CRMD_RESET;
            prmd        <= '0;
            estat_ecode <= '0;
            era         <= '0;
            badv        <= '0;
            tlbehi_vppn <= '0;
            pgdl_base   <= '0;
            pgdh_base   <= '0;
            pgd_base    <= '0;
            eentry      <= '0;
            tlbrentry   <= '0;
        end else begin
            if (exc_upd.take) begin
                prmd.pplv   <= crmd.plv;
                prmd.pie    <= crmd.ie;
                crmd.plv    <= 2'd0;                 // Handler runs in kernel mode
                crmd.ie     <= 1'b0;
                era         <= exc_upd.era;
                estat_ecode <= exc_upd.ecode;
                if (exc_upd.to_direct) begin
                    crmd.da <= 1'b1;
                    crmd.pg <= 1'b0;
                end
            end else begin
                if (sw_hit(CSR_CRMD)) begin
                    crmd.plv <= sw_crmd.plv;
                    crmd.ie  <= sw_crmd.ie;
                    crmd.da  <= sw_crmd.da;
                    crmd.pg  <= sw_crmd.pg;
                end
                if (sw_hit(CSR_PRMD)) begin
                    prmd.pplv <= sw_prmd.pplv;
                    prmd.pie  <= sw_prmd.pie;
                end
                if (sw_hit(CSR_ERA)) era <= csr_wr.data;
            end

            if (exc_upd.badv_wen) begin
                badv     <= exc_upd.badv;
                pgd_base <= exc_upd.pgd_sel_high ? pgdh_base : pgdl_base;
            end else if (sw_hit(CSR_BADV)) begin
                badv <= csr_wr.data;
            end

            if (exc_upd.vppn_wen) begin
                tlbehi_vppn <= exc_upd.vppn;
            end else if (sw_hit(CSR_TLBEHI)) begin
                tlbehi_vppn <= csr_wr.data[31:32-VPPN_W];
            end

            if (sw_hit(CSR_PGDL))      pgdl_base <= csr_wr.data[31:32-PGD_BASE_W];
            if (sw_hit(CSR_PGDH))      pgdh_base <= csr_wr.data[31:32-PGD_BASE_W];
            if (sw_hit(CSR_EENTRY))    eentry    <= csr_wr.data;
            if (sw_hit(CSR_TLBRENTRY)) tlbrentry <= csr_wr.data;
        end
    end

    always_comb begin
        rdata = '0;
        case (raddr)
            CSR_CRMD:      rdata = crmd;
            CSR_PRMD:      rdata = prmd;
            CSR_ESTAT:     rdata = {{(16-ECODE_W){1'b0}}, estat_ecode, 16'd0};  // Code at bit 16
            CSR_ERA:       rdata = era;
            CSR_BADV:      rdata = badv;
            CSR_EENTRY:    rdata = eentry;
            CSR_TLBEHI:    rdata = {tlbehi_vppn, {(32-VPPN_W){1'b0}}};
            CSR_PGDL:      rdata = {pgdl_base, {(32-PGD_BASE_W){1'b0}}};
            CSR_PGDH:      rdata = {pgdh_base, {(32-PGD_BASE_W){1'b0}}};
            CSR_PGD:       rdata = {pgd_base, {(32-PGD_BASE_W){1'b0}}};
            CSR_TLBRENTRY: rdata = tlbrentry;
            default:       rdata = '0;
        endcase
    end

    a_vppn_has_badv: assert property (
        @(posedge clk) disable iff (!arst_n) exc_upd.vppn_wen |-> exc_upd.badv_wen
    ) else $error("VPPN update without BADV update");

    a_badv_needs_take: assert property (
        @(posedge clk) disable iff (!arst_n) exc_upd.badv_wen |-> exc_upd.take
    ) else $error("BADV update outside an exception");

endmodule

//--- la_csr_pkg.sv
package la_csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int ECODE_W    = 7;
    localparam int VPPN_W     = 19;
    localparam int PGD_BASE_W = 20;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CSR numbers and field layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_CRMD      = 14'h000,
        CSR_PRMD      = 14'h001,
        CSR_ESTAT     = 14'h005,
        CSR_ERA       = 14'h006,
        CSR_BADV      = 14'h007,
        CSR_EENTRY    = 14'h00c,
        CSR_TLBEHI    = 14'h011,
        CSR_PGDL      = 14'h019,
        CSR_PGDH      = 14'h01a,
        CSR_PGD       = 14'h01b,
        CSR_TLBRENTRY = 14'h088
    } csr_addr_t;

    typedef struct packed {
        logic [26:0] rsvd;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    localparam crmd_t CRMD_RESET = '{rsvd: '0, pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'd0};

    typedef struct packed {
        logic        en;
        csr_addr_t   addr;
        logic [31:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic              take;        // Save state, write ERA and ESTAT
        logic [31:0]       era;
        logic [ECODE_W-1:0] ecode;
        logic              badv_wen;    // Also latches PGD
        logic [31:0]       badv;
        logic              vppn_wen;
        logic [VPPN_W-1:0] vppn;
        logic              pgd_sel_high;
        logic              to_direct;   // TLB refill drops to direct translation
    } exc_upd_t;

    typedef struct packed {
        logic        set_pc;
        logic [31:0] pc;
    } redirect_t;

endpackage

//--- la_exc_pkg.sv
package la_exc_pkg;

    localparam int EXC_CODE_W = 7;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Exception codes raised by the execution units
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [EXC_CODE_W-1:0] {
        EXC_NONE = 7'd0,
        EXC_TLBR = 7'd1,                // TLB refill
        EXC_PIL  = 7'd2,
        EXC_PIS  = 7'd3,
        EXC_PIF  = 7'd4,
        EXC_PME  = 7'd5,
        EXC_PPI  = 7'd6,
        EXC_ADEF = 7'd7,                // Fetch address error
        EXC_ADEM = 7'd8,                // Memory access address error
        EXC_ALE  = 7'd9,
        EXC_SYS  = 7'd10,
        EXC_BRK  = 7'd11,
        EXC_INE  = 7'd12
    } exc_code_t;

    // One result per slot as it leaves an execution unit
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] inst;
        exc_code_t   exc;               // Only meaningful in slot 0
        logic [31:0] badv;              // Only meaningful in slot 0
    } eu_result_t;

    // Debug trace of one committed instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rf_wen;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
        logic [31:0] inst;
    } wb_trace_t;

endpackage

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        wen0,
    input  logic [4:0]  waddr0,
    input  logic [31:0] wdata0,
    input  logic        wen1,
    input  logic [4:0]  waddr1,
    input  logic [31:0] wdata1,

    input  logic [4:0]  raddr0,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata0,
    output logic [31:0] rdata1
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen0 && (waddr0 != 5'd0)) begin
                regs[waddr0] <= wdata0;
            end
            if (wen1 && (waddr1 != 5'd0)) begin
                regs[waddr1] <= wdata1;     // Issued last so slot 1 wins on a shared rd
            end
        end
    end

    // r0 is never written, so a plain array read returns zero for it
    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];

    a_r0_zero_0: assert property (
        @(posedge clk) disable iff (!arst_n) (raddr0 == 5'd0) |-> (rdata0 == '0)
    ) else $error("r0 read on port 0 returned %h", rdata0);

    a_r0_zero_1: assert property (
        @(posedge clk) disable iff (!arst_n) (raddr1 == 5'd0) |-> (rdata1 == '0)
    ) else $error("r0 read on port 1 returned %h", rdata1);

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

//--- tb_wb_top.sv
`timescale 1ns/1ps

module tb_wb_top
    import la_exc_pkg::*;
    import la_csr_pkg::*;
();

    localparam int NUM_TESTS = 6;

    logic        clk;
    logic        arst_n;
    eu_result_t  eu0;
    eu_result_t  eu1;
    csr_wr_t     csr_wr;
    csr_addr_t   csr_raddr;
    logic [4:0]  rf_raddr0;
    logic [4:0]  rf_raddr1;
    redirect_t   redirect;
    wb_trace_t   trace0;
    wb_trace_t   trace1;
    logic [31:0] csr_rdata;
    logic [31:0] rf_rdata0;
    logic [31:0] rf_rdata1;

    integer      seed;
    int          errors;
    logic [31:0] ref_rf [32];
    logic [31:0] ref_csr [1 << CSR_ADDR_W];

    tb_clkgen u_clkgen (.clk(clk), .arst_n(arst_n));

    wb_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .eu0       (eu0),
        .eu1       (eu1),
        .csr_wr    (csr_wr),
        .csr_raddr (csr_raddr),
        .rf_raddr0 (rf_raddr0),
        .rf_raddr1 (rf_raddr1),
        .redirect  (redirect),
        .trace0    (trace0),
        .trace1    (trace1),
        .csr_rdata (csr_rdata),
        .rf_rdata0 (rf_rdata0),
        .rf_rdata1 (rf_rdata1)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic eu_result_t make_result(input logic [4:0] rd, input exc_code_t exc,
                                               input logic [31:0] badv);
        eu_result_t r;
        r.valid = 1'b1;
        r.data  = $random(seed);
        r.rd    = rd;
        r.pc    = $random(seed) & 32'hffff_fffc;
        r.inst  = $random(seed);
        r.exc   = exc;
        r.badv  = badv;
        return r;
    endfunction

    function automatic logic [31:0] sw_mask(input csr_addr_t a);
        case (a)
            CSR_CRMD:           return 32'h0000_001f;
            CSR_PRMD:           return 32'h0000_0007;
            CSR_ESTAT, CSR_PGD: return 32'h0000_0000;
            CSR_TLBEHI:         return 32'hffff_e000;
            CSR_PGDL, CSR_PGDH: return 32'hffff_f000;
            default:            return 32'hffff_ffff;
        endcase
    endfunction

    task automatic check_trace(input string name, input wb_trace_t t, input eu_result_t e,
                               input logic wen);
        check({name, ".rf_wen"}, 32'(t.rf_wen), wen ? 32'hf : 32'h0);
        if (e.valid) begin
            check({name, ".pc"}, t.pc, e.pc);
            check({name, ".rf_wnum"}, 32'(t.rf_wnum), 32'(e.rd));
            check({name, ".rf_wdata"}, t.rf_wdata, e.data);
            check({name, ".inst"}, t.inst, e.inst);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One commit cycle with the reference model update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic commit(input eu_result_t e0, input eu_result_t e1, input csr_wr_t sw);
        logic        take;
        logic        badv_w;
        logic        vppn_w;
        logic        sw_lost;
        logic [31:0] crmd_old;
        logic [31:0] pgd_new;
        logic [31:0] exp_pc;
        take     = e0.valid && (e0.exc != EXC_NONE);
        badv_w   = take && (e0.exc inside {EXC_TLBR, EXC_ADEF, EXC_ADEM, EXC_ALE, EXC_PIL,
                                           EXC_PIS, EXC_PIF, EXC_PME, EXC_PPI});
        vppn_w   = take && (e0.exc inside {EXC_TLBR, EXC_PIL, EXC_PIS, EXC_PIF, EXC_PME,
                                           EXC_PPI});
        sw_lost  = (take && (sw.addr inside {CSR_CRMD, CSR_PRMD, CSR_ERA, CSR_ESTAT}))
                   || (badv_w && (sw.addr inside {CSR_BADV, CSR_PGD}))
                   || (vppn_w && (sw.addr == CSR_TLBEHI));
        crmd_old = ref_csr[CSR_CRMD];
        pgd_new  = e0.badv[31] ? ref_csr[CSR_PGDH] : ref_csr[CSR_PGDL];
        exp_pc   = (e0.exc == EXC_TLBR) ? ref_csr[CSR_TLBRENTRY] : ref_csr[CSR_EENTRY];
        eu0      = e0;
        eu1      = e1;
        csr_wr   = sw;
        #1;
        check("redirect.set_pc", 32'(redirect.set_pc), 32'(take));
        if (take) check("redirect.pc", redirect.pc, exp_pc);
        check_trace("trace0", trace0, e0, e0.valid && !take);
        check_trace("trace1", trace1, e1, e1.valid && !take);
        if (e0.valid && !take && e0.rd != 5'd0) ref_rf[e0.rd] = e0.data;
        if (e1.valid && !take && e1.rd != 5'd0) ref_rf[e1.rd] = e1.data;   // Younger slot last
        if (sw.en && !sw_lost) begin
            ref_csr[sw.addr] = (ref_csr[sw.addr] & ~sw_mask(sw.addr))
                               | (sw.data & sw_mask(sw.addr));
        end
        if (take) begin
            ref_csr[CSR_PRMD]  = {29'd0, crmd_old[2], crmd_old[1:0]};
            ref_csr[CSR_CRMD]  = {27'd0, (e0.exc == EXC_TLBR) ? 2'b01 : crmd_old[4:3], 3'b000};
            ref_csr[CSR_ERA]   = e0.pc;
            ref_csr[CSR_ESTAT] = {9'd0, e0.exc, 16'd0};
        end
        if (badv_w) begin
            ref_csr[CSR_BADV] = e0.badv;
            ref_csr[CSR_PGD]  = pgd_new;
        end
        if (vppn_w) ref_csr[CSR_TLBEHI] = {e0.badv[31:13], 13'd0};
        @(posedge clk);
        #1;
        eu0    = '0;
        eu1    = '0;
        csr_wr = '0;
    endtask

    task automatic csr_write(input csr_addr_t addr, input logic [31:0] data);
        commit('0, '0, '{en: 1'b1, addr: addr, data: data});
    endtask

    task automatic check_regs(input logic [4:0] a, input logic [4:0] b);
        rf_raddr0 = a;
        rf_raddr1 = b;
        #2;
        check($sformatf("rf_rdata0 r%0d", a), rf_rdata0, ref_rf[a]);
        check($sformatf("rf_rdata1 r%0d", b), rf_rdata1, ref_rf[b]);
        @(posedge clk);
        #1;
    endtask

    task automatic check_csr(input csr_addr_t addr);
        csr_raddr = addr;
        #2;
        check({"csr_rdata ", addr.name()}, csr_rdata, ref_csr[addr]);
        @(posedge clk);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_dual_commit();
        commit(make_result(5'd3, EXC_NONE, '0), make_result(5'd7, EXC_NONE, '0), '0);
        check_regs(5'd3, 5'd7);
    endtask

    task automatic test_same_rd();
        commit(make_result(5'd9, EXC_NONE, '0), make_result(5'd9, EXC_NONE, '0), '0);
        check_regs(5'd9, 5'd9);
        commit(make_result(5'd0, EXC_NONE, '0), make_result(5'd0, EXC_NONE, '0), '0);
        check_regs(5'd0, 5'd0);
    endtask

    task automatic test_syscall();
        csr_write(CSR_EENTRY, $random(seed));
        csr_write(CSR_CRMD, 32'h0000_0017);      // Paged mode at PLV 3 with IE set
        commit(make_result(5'd4, EXC_SYS, $random(seed)), make_result(5'd5, EXC_NONE, '0), '0);
        check_regs(5'd4, 5'd5);
        check_csr(CSR_ERA);
        check_csr(CSR_ESTAT);
        check_csr(CSR_PRMD);
        check_csr(CSR_CRMD);
        check_csr(CSR_BADV);
    endtask

    task automatic test_adem();
        csr_write(CSR_PGDL, $random(seed));
        csr_write(CSR_PGDH, $random(seed));
        commit(make_result(5'd6, EXC_ADEM, 32'h8000_0000 | $random(seed)), '0, '0);
        check_csr(CSR_BADV);
        check_csr(CSR_PGD);
        check_csr(CSR_TLBEHI);
        commit(make_result(5'd6, EXC_ADEM, 32'h7fff_ffff & $random(seed)), '0, '0);
        check_csr(CSR_BADV);
        check_csr(CSR_PGD);
    endtask

    task automatic test_tlbr();
        csr_write(CSR_TLBRENTRY, $random(seed));
        csr_write(CSR_CRMD, 32'h0000_0013);      // Paged mode at PLV 3
        commit(make_result(5'd8, EXC_TLBR, $random(seed)), make_result(5'd2, EXC_NONE, '0), '0);
        check_csr(CSR_CRMD);
        check_csr(CSR_TLBEHI);
        check_csr(CSR_BADV);
        check_csr(CSR_ERA);
    endtask

    task automatic test_sw_era();
        commit(make_result(5'd1, EXC_BRK, '0), '0,
               '{en: 1'b1, addr: CSR_ERA, data: $random(seed)});
        check_csr(CSR_ERA);
        csr_write(CSR_ERA, $random(seed));
        check_csr(CSR_ERA);
    endtask

    initial begin
        #(NUM_TESTS * 200);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed      = 32'ha90b_f6f5;
        errors    = 0;
        ref_rf    = '{default: '0};
        ref_csr   = '{default: '0};
        ref_csr[CSR_CRMD] = CRMD_RESET;
        eu0       = '0;
        eu1       = '0;
        csr_wr    = '0;
        csr_raddr = CSR_CRMD;
        rf_raddr0 = '0;
        rf_raddr1 = '0;
        @(posedge arst_n);
        @(posedge clk);
        #1;
        test_dual_commit();
        test_same_rd();
        test_syscall();
        test_adem();
        test_tlbr();
        test_sw_era();
        $display("tests run %0d, errors %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- wb_top.sv
`timescale 1ns/1ps

module wb_top
    import la_exc_pkg::*;
    import la_csr_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    input  eu_result_t  eu0,
    input  eu_result_t  eu1,
    input  csr_wr_t     csr_wr,
    input  csr_addr_t   csr_raddr,
    input  logic [4:0]  rf_raddr0,
    input  logic [4:0]  rf_raddr1,

    output redirect_t   redirect,
    output wb_trace_t   trace0,
    output wb_trace_t   trace1,
    output logic [31:0] csr_rdata,
    output logic [31:0] rf_rdata0,
    output logic [31:0] rf_rdata1
);

    logic        wen0;
    logic        wen1;
    logic [4:0]  waddr0;
    logic [4:0]  waddr1;
    logic [31:0] wdata0;
    logic [31:0] wdata1;
    exc_upd_t    exc_upd;
    logic [31:0] eentry;
    logic [31:0] tlbrentry;

    writeback u_writeback (
        .eu0       (eu0),
        .eu1       (eu1),
        .eentry    (eentry),
        .tlbrentry (tlbrentry),
        .wen0      (wen0),
        .wen1      (wen1),
        .waddr0    (waddr0),
        .waddr1    (waddr1),
        .wdata0    (wdata0),
        .wdata1    (wdata1),
        .exc_upd   (exc_upd),
        .redirect  (redirect),
        .trace0    (trace0),
        .trace1    (trace1)
    );

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .wen0   (wen0),
        .waddr0 (waddr0),
        .wdata0 (wdata0),
        .wen1   (wen1),
        .waddr1 (waddr1),
        .wdata1 (wdata1),
        .raddr0 (rf_raddr0),
        .raddr1 (rf_raddr1),
        .rdata0 (rf_rdata0),
        .rdata1 (rf_rdata1)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .exc_upd   (exc_upd),
        .csr_wr    (csr_wr),
        .raddr     (csr_raddr),
        .rdata     (csr_rdata),
        .eentry    (eentry),
        .tlbrentry (tlbrentry)
    );

endmodule

//--- writeback.sv
`timescale 1ns/1ps

module writeback
    import la_exc_pkg::*;
    import la_csr_pkg::*;
(
    input  eu_result_t  eu0,
    input  eu_result_t  eu1,
    input  logic [31:0] eentry,
    input  logic [31:0] tlbrentry,

    output logic        wen0,
    output logic        wen1,
    output logic [4:0]  waddr0,
    output logic [4:0]  waddr1,
    output logic [31:0] wdata0,
    output logic [31:0] wdata1,

    output exc_upd_t    exc_upd,
    output redirect_t   redirect,
    output wb_trace_t   trace0,
    output wb_trace_t   trace1
);

    logic has_exc;
    logic is_tlbr;
    logic badv_class;
    logic vppn_class;

    assign has_exc = eu0.valid && (eu0.exc != EXC_NONE);
    assign is_tlbr = (eu0.exc == EXC_TLBR);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Exception classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        badv_class = 1'b0;
        vppn_class = 1'b0;
        case (eu0.exc)
            EXC_TLBR, EXC_PIL, EXC_PIS, EXC_PIF, EXC_PME, EXC_PPI: begin
                badv_class = 1'b1;              // Translation faults also report the VPPN
                vppn_class = 1'b1;
            end
            EXC_ADEF, EXC_ADEM, EXC_ALE: begin
                badv_class = 1'b1;
            end
            default: begin
                badv_class = 1'b0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register file writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wen0   = eu0.valid && (eu0.exc == EXC_NONE);
    assign wen1   = eu1.valid && !has_exc;     // Younger slot dies behind a slot 0 exception
    assign waddr0 = eu0.rd;
    assign waddr1 = eu1.rd;
    assign wdata0 = eu0.data;
    assign wdata1 = eu1.data;

    assign redirect.set_pc = has_exc;
    assign redirect.pc     = is_tlbr ? tlbrentry : eentry;

    assign exc_upd.take         = has_exc;
    assign exc_upd.era          = eu0.pc;
    assign exc_upd.ecode        = eu0.exc;
    assign exc_upd.badv_wen     = has_exc && badv_class;
    assign exc_upd.badv         = eu0.badv;
    assign exc_upd.vppn_wen     = has_exc && vppn_class;
    assign exc_upd.vppn         = eu0.badv[31:32-VPPN_W];
    assign exc_upd.pgd_sel_high = eu0.badv[31];          // Upper half of the address space uses PGDH
    assign exc_upd.to_direct    = has_exc && is_tlbr;

    assign trace0 = '{pc: eu0.pc, rf_wen: {4{wen0}}, rf_wnum: eu0.rd,
                      rf_wdata: eu0.data, inst: eu0.inst};
    assign trace1 = '{pc: eu1.pc, rf_wen: {4{wen1}}, rf_wnum: eu1.rd,
                      rf_wdata: eu1.data, inst: eu1.inst};

    always_comb begin
        assert (!(wen1 && redirect.set_pc))
            else $error("slot 1 committed behind a redirect");
        assert (!redirect.set_pc || eu0.valid)
            else $error("redirect without a valid slot 0 result");
    end

endmodule
